//--- logic/alu.sv
// combinational 4-bit ALU for add, subtract, and, or
`timescale 1ns/1ps

module alu (
  input  sap4Pkg::aluOpE aluOp,
  input  sap4Pkg::dataT  opA,
  input  sap4Pkg::dataT  opB,
  output sap4Pkg::dataT  result
);

  // no carry out, results wrap at 4 bits
  always_comb
  begin
    case (aluOp)
      sap4Pkg::aluAdd:
        result = opA + opB;
      sap4Pkg::aluSub:
        result = opA - opB;
      sap4Pkg::aluAnd:
        result = opA & opB;
      sap4Pkg::aluOr:
        result = opA | opB;
      default:
        result = '0;
    endcase
  end

endmodule

//--- logic/controlSequencer.sv
// six-step ring sequencer with halt latch, turns ring step and opcode into control strobes
`timescale 1ns/1ps

module controlSequencer (
  input  logic             clk,
  input  logic             reset,
  input  sap4Pkg::opcodeE  opcode,
  output logic             marFromPc,
  output logic             pcInc,
  output logic             irLoad,
  output logic             marFromIr,
  output logic             memWrite,
  output logic             aFromMem,
  output logic             aFromAlu,
  output logic             aFromB,
  output logic             tmpFromA,
  output logic             tmpFromMem,
  output logic             bFromTmp,
  output logic             bFromAlu,
  output logic             outLoad,
  output logic             halted,
  output sap4Pkg::aluOpE   aluOp
);

  sap4Pkg::ringStepT ringStep;

  // ring advances every cycle until a hlt is seen at t4
  always_ff @(posedge clk)
  begin
    if (!reset)
    begin
      ringStep <= sap4Pkg::stepT1;
      halted   <= 1'b0;
    end
    else if (!halted)
    begin
      ringStep <= (ringStep == sap4Pkg::stepT6) ? sap4Pkg::stepT1 : ringStep << 1;
      if (ringStep == sap4Pkg::stepT4 && opcode == sap4Pkg::opHlt)
        halted <= 1'b1; // ring stays frozen from here on
    end
  end

  always_comb
  begin
    marFromPc  = 1'b0;
    pcInc      = 1'b0;
    irLoad     = 1'b0;
    marFromIr  = 1'b0;
    memWrite   = 1'b0;
    aFromMem   = 1'b0;
    aFromAlu   = 1'b0;
    aFromB     = 1'b0;
    tmpFromA   = 1'b0;
    tmpFromMem = 1'b0;
    bFromTmp   = 1'b0;
    bFromAlu   = 1'b0;
    outLoad    = 1'b0;
    if (!halted)
    begin
      case (ringStep)
        sap4Pkg::stepT1: marFromPc = 1'b1;
        sap4Pkg::stepT2: pcInc = 1'b1;
        sap4Pkg::stepT3: irLoad = 1'b1;
        sap4Pkg::stepT4:
        begin
          case (opcode)
            sap4Pkg::opMovAMem, sap4Pkg::opMovMemA, sap4Pkg::opOrBMem: marFromIr = 1'b1;
            sap4Pkg::opAdd, sap4Pkg::opSub, sap4Pkg::opAnd: aFromAlu = 1'b1;
            sap4Pkg::opXchg: tmpFromA = 1'b1;
            sap4Pkg::opOut:  outLoad = 1'b1;
            default: ; // unused opcodes idle through the step
          endcase
        end
        sap4Pkg::stepT5:
        begin
          case (opcode)
            sap4Pkg::opMovAMem: aFromMem = 1'b1;
            sap4Pkg::opMovMemA: memWrite = 1'b1;
            sap4Pkg::opOrBMem:  tmpFromMem = 1'b1;
            sap4Pkg::opXchg:    aFromB = 1'b1;
            default: ;
          endcase
        end
        sap4Pkg::stepT6:
        begin
          case (opcode)
            sap4Pkg::opOrBMem: bFromAlu = 1'b1; // b gets tmp | b
            sap4Pkg::opXchg:   bFromTmp = 1'b1;
            default: ;
          endcase
        end
        default: ;
      endcase
    end
  end

  // or b,[addr] is the only user of the or path
  always_comb
  begin
    case (opcode)
      sap4Pkg::opSub:    aluOp = sap4Pkg::aluSub;
      sap4Pkg::opAnd:    aluOp = sap4Pkg::aluAnd;
      sap4Pkg::opOrBMem: aluOp = sap4Pkg::aluOr;
      default:           aluOp = sap4Pkg::aluAdd;
    endcase
  end

endmodule

//--- logic/fetchUnit.sv
// program counter, memory address register and instruction register of the fetch path
`timescale 1ns/1ps

module fetchUnit (
  input  logic             clk,
  input  logic             reset,
  input  logic             marFromPc,
  input  logic             pcInc,
  input  logic             irLoad,
  input  logic             marFromIr,
  input  sap4Pkg::ramWordU memWord,
  output sap4Pkg::addrT    memAddr,
  output sap4Pkg::opcodeE  opcode
);

  sap4Pkg::addrT pc;
  sap4Pkg::addrT mar;
  sap4Pkg::addrT irOperand; // address field, only feeds the mar

  always_ff @(posedge clk)
  begin
    if (!reset)
    begin
      pc  <= '0;
      mar <= '0;
    end
    else
    begin
      if (pcInc)
        pc <= pc + 1'b1; // wraps 15 to 0
      if (marFromPc)
        mar <= pc;
      else if (marFromIr)
        mar <= irOperand;
    end
  end

  // instruction view of the fetched word
  always_ff @(posedge clk)
  begin
    if (irLoad)
    begin
      opcode    <= memWord.instr.opcode;
      irOperand <= memWord.instr.operand;
    end
  end

  assign memAddr = mar;

endmodule

//--- logic/programMemory.sv
// sixteen-word program and data memory, loaded before the run and stored into by mov [addr],a
`timescale 1ns/1ps

`include "sap4_params.svh"

module programMemory (
  input  logic             clk,
  input  logic             progWrite,
  input  sap4Pkg::addrT    progAddr,
  input  sap4Pkg::ramWordU progData,
  input  logic             memWrite,
  input  sap4Pkg::addrT    memAddr,
  input  sap4Pkg::dataT    aValue,
  output sap4Pkg::ramWordU memWord
);

  sap4Pkg::ramWordU mem [`SAP_RAM_DEPTH];
  sap4Pkg::ramWordU storeWord;

  // a stored nibble lands in the data view, upper nibble cleared
  always_comb
  begin
    storeWord.data.unused = '0;
    storeWord.data.value  = aValue;
  end

  always_ff @(posedge clk)
  begin
    if (progWrite)
      mem[progAddr] <= progData; // loader wins over a store
    else if (memWrite)
      mem[memAddr] <= storeWord;
  end

  assign memWord = mem[memAddr]; // asynchronous read

endmodule

//--- logic/registerDatapath.sv
// accumulator, B, temporary and output registers with their load muxes around the ALU
`timescale 1ns/1ps

module registerDatapath (
  input  logic           clk,
  input  logic           reset,
  input  logic           aFromMem,
  input  logic           aFromAlu,
  input  logic           aFromB,
  input  logic           tmpFromA,
  input  logic           tmpFromMem,
  input  logic           bFromTmp,
  input  logic           bFromAlu,
  input  logic           outLoad,
  input  sap4Pkg::aluOpE aluOp,
  input  sap4Pkg::dataT  memData,
  output sap4Pkg::dataT  aValue,
  output sap4Pkg::dataT  outValue,
  output logic           outValid
);

  sap4Pkg::dataT aReg;
  sap4Pkg::dataT bReg;
  sap4Pkg::dataT tmpReg;
  sap4Pkg::dataT aluOpA;
  sap4Pkg::dataT aluResult;

  // or b,[addr] works on tmp, the arithmetic ops on A
  assign aluOpA = bFromAlu ? tmpReg : aReg;

  alu aluInst (
    .aluOp  (aluOp),
    .opA    (aluOpA),
    .opB    (bReg),
    .result (aluResult)
  );

  always_ff @(posedge clk)
  begin
    if (!reset)
    begin
      aReg     <= '0;
      bReg     <= '0;
      tmpReg   <= '0;
      outValue <= '0;
      outValid <= 1'b0;
    end
    else
    begin
      if (aFromMem)
        aReg <= memData;
      else if (aFromAlu)
        aReg <= aluResult;
      else if (aFromB)
        aReg <= bReg; // second half of xchg

      if (tmpFromA)
        tmpReg <= aReg;
      else if (tmpFromMem)
        tmpReg <= memData;

      if (bFromTmp)
        bReg <= tmpReg;
      else if (bFromAlu)
        bReg <= aluResult;

      if (outLoad)
        outValue <= aReg;
      outValid <= outLoad; // single-cycle strobe
    end
  end

  assign aValue = aReg;

endmodule

//--- logic/sap4Pkg.sv
// shared types of the 4-bit processor, referenced by scoped names from every RTL file
package sap4Pkg;

  `include "sap4_params.svh"

  typedef logic [`SAP_DATA_W-1:0] dataT;
  typedef logic [`SAP_ADDR_W-1:0] addrT;

  typedef enum logic [3:0] {
    opAdd     = 4'b0001, // add a,b
    opSub     = 4'b0010, // sub a,b
    opXchg    = 4'b0011, // xchg a,b
    opMovMemA = 4'b0110, // mov [addr],a
    opMovAMem = 4'b0111, // mov a,[addr]
    opAnd     = 4'b1000, // and a,b
    opOrBMem  = 4'b1001, // or b,[addr]
    opOut     = 4'b1010, // out a
    opHlt     = 4'b1111  // hlt
  } opcodeE;

  typedef enum logic [1:0] {aluAdd, aluSub, aluAnd, aluOr} aluOpE;

  // one-hot ring position
  typedef logic [`SAP_RING_LEN-1:0] ringStepT;

  localparam ringStepT stepT1 = 6'b000001;
  localparam ringStepT stepT2 = 6'b000010;
  localparam ringStepT stepT3 = 6'b000100;
  localparam ringStepT stepT4 = 6'b001000;
  localparam ringStepT stepT5 = 6'b010000;
  localparam ringStepT stepT6 = 6'b100000;

  // same memory word seen as an instruction or as a data nibble
  typedef union packed {
    struct packed {
      opcodeE opcode;
      addrT   operand;
    } instr;
    struct packed {
      logic [`SAP_WORD_W-`SAP_DATA_W-1:0] unused;
      dataT                               value;
    } data;
  } ramWordU;

endpackage

//--- logic/sap4Top.sv
// top level of the 4-bit processor, joins sequencer, fetch unit, memory and datapath
`timescale 1ns/1ps

module sap4Top (
  input  logic             clk,
  input  logic             reset,
  input  logic             progWrite,
  input  sap4Pkg::addrT    progAddr,
  input  sap4Pkg::ramWordU progData,
  output sap4Pkg::dataT    outValue,
  output logic             outValid,
  output logic             halted
);

  logic marFromPc;
  logic pcInc;
  logic irLoad;
  logic marFromIr;
  logic memWrite;
  logic aFromMem;
  logic aFromAlu;
  logic aFromB;
  logic tmpFromA;
  logic tmpFromMem;
  logic bFromTmp;
  logic bFromAlu;
  logic outLoad;

  sap4Pkg::aluOpE   aluOp;
  sap4Pkg::opcodeE  opcode;
  sap4Pkg::addrT    memAddr;
  sap4Pkg::ramWordU memWord;
  sap4Pkg::dataT    aValue;

  controlSequencer sequencerInst (
    .clk        (clk),
    .reset      (reset),
    .opcode     (opcode),
    .marFromPc  (marFromPc),
    .pcInc      (pcInc),
    .irLoad     (irLoad),
    .marFromIr  (marFromIr),
    .memWrite   (memWrite),
    .aFromMem   (aFromMem),
    .aFromAlu   (aFromAlu),
    .aFromB     (aFromB),
    .tmpFromA   (tmpFromA),
    .tmpFromMem (tmpFromMem),
    .bFromTmp   (bFromTmp),
    .bFromAlu   (bFromAlu),
    .outLoad    (outLoad),
    .halted     (halted),
    .aluOp      (aluOp)
  );

  fetchUnit fetchInst (
    .clk       (clk),
    .reset     (reset),
    .marFromPc (marFromPc),
    .pcInc     (pcInc),
    .irLoad    (irLoad),
    .marFromIr (marFromIr),
    .memWord   (memWord),
    .memAddr   (memAddr),
    .opcode    (opcode)
  );

  programMemory memoryInst (
    .clk       (clk),
    .progWrite (progWrite),
    .progAddr  (progAddr),
    .progData  (progData),
    .memWrite  (memWrite),
    .memAddr   (memAddr),
    .aValue    (aValue),
    .memWord   (memWord)
  );

  // datapath only ever sees the data view of the word
  registerDatapath datapathInst (
    .clk        (clk),
    .reset      (reset),
    .aFromMem   (aFromMem),
    .aFromAlu   (aFromAlu),
    .aFromB     (aFromB),
    .tmpFromA   (tmpFromA),
    .tmpFromMem (tmpFromMem),
    .bFromTmp   (bFromTmp),
    .bFromAlu   (bFromAlu),
    .outLoad    (outLoad),
    .aluOp      (aluOp),
    .memData    (memWord.data.value),
    .aValue     (aValue),
    .outValue   (outValue),
    .outValid   (outValid)
  );

endmodule

//--- logic/sap4_params.svh
// widths, memory depth and ring length of the 4-bit processor, included by package and RTL
`ifndef SAP4_PARAMS_SVH
`define SAP4_PARAMS_SVH

// datapath nibble
`define SAP_DATA_W 4

// program memory addressing
`define SAP_ADDR_W 4
`define SAP_WORD_W 8
`define SAP_RAM_DEPTH 16

// one-hot steps per instruction
`define SAP_RING_LEN 6

`endif

//--- sap4.f
+incdir+logic
logic/sap4Pkg.sv
logic/alu.sv
logic/controlSequencer.sv
logic/fetchUnit.sv
logic/programMemory.sv
logic/registerDatapath.sv
logic/sap4Top.sv
verif/sap4Checker.sv
verif/sap4Tb.sv

//--- verif/sap4Checker.sv
// testbench checker, watches the output strobe and halt of the processor and counts mismatches
`timescale 1ns/1ps

`include "sap4_params.svh"

module sap4Checker (
  input  logic        clk,
  input  logic        reset,
  input  logic [3:0]  outValue,
  input  logic        outValid,
  input  logic        halted,
  input  logic [15:0] expValues,    // one nibble per output, first output in the low nibble
  input  logic [15:0] expPositions, // program position of each out instruction
  input  logic [2:0]  expCount,
  input  logic        endCheck,
  output int          errorCount
);

  int runCycle = 0; // rising edges since reset was released
  int strobeIdx = 0;
  int lastStrobe = 0;
  int strobeErrors = 0;
  int countErrors = 0;
  int wantGap;
  logic haltSeen = 1'b0;
  logic [3:0] wantValue;
  logic [3:0] wantPos;
  logic [3:0] prevPos;

  assign errorCount = strobeErrors + countErrors;

  always @(posedge clk)
  begin
    runCycle <= reset ? runCycle + 1 : 0;
    if (endCheck && strobeIdx != expCount)
    begin
      $display("program ended with %0d output strobes, expected %0d", strobeIdx, expCount);
      countErrors = countErrors + 1;
    end
  end

  // outputs are registered, so the falling edge sees them settled
  always @(negedge clk)
  begin
    if (runCycle == 0)
    begin
      strobeIdx = 0;
      haltSeen  = 1'b0;
    end
    else
    begin
      if (haltSeen && !halted)
      begin
        $display("halted dropped in cycle %0d without a reset", runCycle);
        strobeErrors = strobeErrors + 1;
      end
      if (outValid)
      begin
        if (haltSeen || strobeIdx >= expCount)
        begin
          $display("unexpected output strobe in cycle %0d", runCycle);
          strobeErrors = strobeErrors + 1;
        end
        else
        begin
          wantValue = expValues[strobeIdx*4 +: 4];
          wantPos   = expPositions[strobeIdx*4 +: 4];
          if (outValue !== wantValue)
          begin
            $display("[FAIL] outValue expected 0x%h actual 0x%h", wantValue, outValue);
            strobeErrors = strobeErrors + 1;
          end
          if (strobeIdx == 0 && runCycle != `SAP_RING_LEN * wantPos + 4)
          begin
            $display("first strobe came in cycle %0d, expected cycle %0d",
                     runCycle, `SAP_RING_LEN * wantPos + 4);
            strobeErrors = strobeErrors + 1;
          end
          else if (strobeIdx > 0)
          begin
            prevPos = expPositions[(strobeIdx-1)*4 +: 4];
            wantGap = `SAP_RING_LEN * (wantPos - prevPos); // six per instruction in between
            if (runCycle - lastStrobe != wantGap)
            begin
              $display("strobe %0d came %0d cycles after the previous one, expected %0d",
                       strobeIdx, runCycle - lastStrobe, wantGap);
              strobeErrors = strobeErrors + 1;
            end
          end
        end
        lastStrobe = runCycle;
        strobeIdx  = strobeIdx + 1;
      end
      if (halted)
        haltSeen = 1'b1;
    end
  end

endmodule

//--- verif/sap4Tb.sv
// testbench top, loads each table program through the load port, runs it to halt and reports
`timescale 1ns/1ps

`include "sap4_params.svh"

module sap4Tb;

  localparam int numPrograms = 4;
  localparam int haltWatch = 20; // quiet cycles expected after hlt
  localparam int cycleLimit =
    numPrograms * (4 + `SAP_RAM_DEPTH + `SAP_RAM_DEPTH * `SAP_RING_LEN + 12);

  logic clk;
  logic reset;
  logic progWrite;
  sap4Pkg::addrT progAddr;
  sap4Pkg::ramWordU progData;
  sap4Pkg::dataT outValue;
  logic outValid;
  logic halted;

  // program table, expected outputs packed low nibble first
  logic [7:0]  progTable [numPrograms][16];
  logic [15:0] expValueTable [numPrograms];
  logic [15:0] expPosTable [numPrograms];
  logic [2:0]  expCountTable [numPrograms];

  logic [15:0] expValues;
  logic [15:0] expPositions;
  logic [2:0]  expCount;
  logic endCheck;
  int checkErrors;
  int tbErrors = 0;
  int cycleCount = 0;
  int seedValue;
  int p;

  sap4Top UUT (
    .clk       (clk),
    .reset     (reset),
    .progWrite (progWrite),
    .progAddr  (progAddr),
    .progData  (progData),
    .outValue  (outValue),
    .outValid  (outValid),
    .halted    (halted)
  );

  sap4Checker checkerInst (
    .clk          (clk),
    .reset        (reset),
    .outValue     (outValue),
    .outValid     (outValid),
    .halted       (halted),
    .expValues    (expValues),
    .expPositions (expPositions),
    .expCount     (expCount),
    .endCheck     (endCheck),
    .errorCount   (checkErrors)
  );

  always #10 clk = ~clk;

  task automatic buildTable;
    logic [3:0] rx;
    logic [3:0] ry;
    logic [3:0] sumXY;
    begin
      rx    = $urandom & 4'hF;
      ry    = $urandom & 4'hF;
      sumXY = rx + ry; // wraps at 4 bits
      // load, store, reload
      progTable[0] = '{8'h7E, 8'hA0, 8'h6F, 8'h7F, 8'hA0, 8'hF0, 8'h00, 8'h00,
                       8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h0B, 8'h05};
      // clear B, or in rx, then add, sub, and with ry
      progTable[1] = '{8'h7D, 8'h30, 8'h9E, 8'h7F, 8'h10, 8'hA0, 8'h20, 8'hA0,
                       8'h80, 8'hA0, 8'hF0, 8'h00, 8'h00, 8'h00, {4'h0, rx}, {4'h0, ry}};
      progTable[2] = '{8'h7E, 8'h30, 8'h7F, 8'h30, 8'hA0, 8'h30, 8'hA0, 8'hF0,
                       8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h06, 8'h09};
      // dropped opcodes between outs
      progTable[3] = '{8'h7F, 8'hA0, 8'h40, 8'h50, 8'h00, 8'hA0, 8'hA0, 8'hF0,
                       8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h0C};
      expValueTable = '{16'h00BB, {4'h0, ry & rx, ry, sumXY}, 16'h0096, 16'h0CCC};
      expPosTable   = '{16'h0041, 16'h0975, 16'h0064, 16'h0651};
      expCountTable = '{3'd2, 3'd3, 3'd2, 3'd3};
    end
  endtask

  // reset for four cycles, then write all words with reset still low
  task automatic loadProgram(input int idx);
    int a;
    begin
      @(negedge clk);
      reset = 1'b0;
      repeat (4) @(negedge clk);
      expValues    = expValueTable[idx];
      expPositions = expPosTable[idx];
      expCount     = expCountTable[idx];
      for (a = 0; a < `SAP_RAM_DEPTH; a++)
      begin
        progWrite = 1'b1;
        progAddr  = a;
        progData  = progTable[idx][a];
        @(negedge clk);
      end
      progWrite = 1'b0;
      reset     = 1'b1;
    end
  endtask

  task automatic runToHalt;
    begin
      while (!halted)
        @(negedge clk);
      repeat (haltWatch) @(negedge clk);
      endCheck = 1'b1; // checker compares the strobe count
      @(negedge clk);
      endCheck = 1'b0;
    end
  endtask

  task finishRun;
    begin
      $display("errors: %0d checker, %0d testbench, %0d total",
               checkErrors, tbErrors, checkErrors + tbErrors);
      if (checkErrors + tbErrors == 0)
        $display("*** PASSED ***");
      else
        $display("*** FAILED ***");
      $finish;
    end
  endtask

  always @(posedge clk)
  begin
    cycleCount = cycleCount + 1;
    if (cycleCount >= cycleLimit)
    begin
      $display("timeout, the run did not finish within %0d clock cycles", cycleLimit);
      tbErrors = tbErrors + 1;
      finishRun();
    end
  end

  initial
  begin
    clk          = 1'b0;
    reset        = 1'b0;
    progWrite    = 1'b0;
    progAddr     = '0;
    progData     = '0;
    endCheck     = 1'b0;
    expValues    = '0;
    expPositions = '0;
    expCount     = '0;
    seedValue    = $urandom(32'he0cf);
    buildTable();
    // first program is cut short after its first output and rerun
    loadProgram(0);
    while (!outValid)
      @(negedge clk);
    repeat (3) @(negedge clk);
    loadProgram(0);
    runToHalt();
    for (p = 1; p < numPrograms; p++)
    begin
      loadProgram(p);
      runToHalt();
    end
    finishRun();
  end

endmodule
